/* files.f */
rtl/csr_pkg.sv
rtl/csr_file.sv
rtl/csr_alu.sv
rtl/trap_unit.sv
rtl/commit_ctrl.sv
rtl/csr_unit.sv
tests/tb_csr_unit.sv

/* Makefile */
# Verilator flow for the CSR unit testbench

VERILATOR ?= verilator
TOP       ?= tb_csr_unit
RTL_TOP   ?= csr_unit
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_csr_unit.sv */
// ==========================================================================
// CSR unit testbench
// ==========================================================================
`timescale 1ns/1ps

module tb_csr_unit;
  import csr_pkg::*;

  // polling steps allowed per wait
  localparam int step_limit = 20;

  logic        clk;
  logic        rst;
  logic        valid;
  csr_op_e     op;
  csr_addr_t   addr;
  logic [31:0] src;
  logic        src_zero;
  logic        fetch_misaligned;
  logic        illegal_instr;
  logic        ebreak;
  logic        ecall;
  logic        mret;
  logic [31:0] pc;
  logic [31:0] fetch_target;
  logic [31:0] rd_data;
  logic        rd_we;
  logic        trap;
  logic        redirect;
  logic [31:0] redirect_pc;

  // random source, model of the writable CSRs and scratch words
  logic [31:0] lfsr;
  logic [31:0] m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval;
  logic [31:0] w, s, p, f;

  csr_unit #(
    .hart_id     (32'd3),
    .mtvec_reset (32'h100)
  ) uut (
    .clk              (clk),
    .rst              (rst),
    .valid            (valid),
    .op               (op),
    .addr             (addr),
    .src              (src),
    .src_zero         (src_zero),
    .fetch_misaligned (fetch_misaligned),
    .illegal_instr    (illegal_instr),
    .ebreak           (ebreak),
    .ecall            (ecall),
    .mret             (mret),
    .pc               (pc),
    .fetch_target     (fetch_target),
    .rd_data          (rd_data),
    .rd_we            (rd_we),
    .trap             (trap),
    .redirect         (redirect),
    .redirect_pc      (redirect_pc)
  );

  always #5 clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] x);
    return {x[30:0], x[31] ^ x[21] ^ x[1] ^ x[0]};
  endfunction

  // one step per bit taken
  function automatic logic [31:0] rand_word();
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else fail_run($sformatf("error: %s = %08h, expected %08h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp)
    else fail_run($sformatf("error: %s = %0h, expected %0h", name, got, exp));
  endtask

  // poll through the high phase into the next low phase
  task automatic wait_fall();
    int n;
    n = 0;
    while (clk !== 1'b1 && n < step_limit) begin
      #1;
      n++;
    end
    while (clk !== 1'b0 && n < step_limit) begin
      #1;
      n++;
    end
    if (n >= step_limit) fail_run("timeout: the clock stopped toggling");
  endtask

  // combinational outputs need a moment after the inputs change
  task automatic settle();
    int n;
    n = 0;
    do begin
      #1;
      n++;
    end while ($isunknown({rd_data, rd_we, trap, redirect, redirect_pc}) && n < 4);
    if ($isunknown({rd_data, rd_we, trap, redirect, redirect_pc}))
      fail_run("timeout: DUT outputs still unknown after the inputs were driven");
  endtask

  task automatic idle_inputs();
    valid            = 1'b0;
    op               = csr_none;
    addr             = '0;
    src              = '0;
    src_zero         = 1'b0;
    fetch_misaligned = 1'b0;
    illegal_instr    = 1'b0;
    ebreak           = 1'b0;
    ecall            = 1'b0;
    mret             = 1'b0;
    pc               = '0;
    fetch_target     = '0;
  endtask

  // the rising edge in between commits the instruction
  task automatic next_cycle();
    wait_fall();
    idle_inputs();
  endtask

  task automatic start_op(input csr_op_e o, input csr_addr_t a, input logic [31:0] v,
                          input logic z);
    valid    = 1'b1;
    op       = o;
    addr     = a;
    src      = v;
    src_zero = z;
    pc       = rand_word();
  endtask

  task automatic expect_commit(input logic [31:0] old);
    check_word("rd_data", rd_data, old);
    check_bit("rd_we", rd_we, 1'b1);
    check_bit("trap", trap, 1'b0);
    check_bit("redirect", redirect, 1'b0);
  endtask

  task automatic expect_trap();
    check_bit("rd_we", rd_we, 1'b0);
    check_bit("trap", trap, 1'b1);
    check_bit("redirect", redirect, 1'b1);
    check_word("redirect_pc", redirect_pc, m_mtvec);
  endtask

  task automatic do_op(input csr_op_e o, input csr_addr_t a, input logic [31:0] v,
                       input logic z, input logic [31:0] old);
    start_op(o, a, v, z);
    settle();
    expect_commit(old);
    next_cycle();
  endtask

  // set with a zero source is a pure read
  task automatic read_csr(input csr_addr_t a, input logic [31:0] exp);
    do_op(csr_set, a, rand_word(), 1'b1, exp);
  endtask

  // exception flags plus a CSR write that must be dropped
  task automatic raise(input logic fm, input logic il, input logic eb, input logic ec,
                       input logic mr, input logic [31:0] cause, input logic [31:0] tval);
    start_op(csr_write, addr_mscratch, rand_word(), 1'b0);
    pc               = p;
    fetch_target     = f;
    fetch_misaligned = fm;
    illegal_instr    = il;
    ebreak           = eb;
    ecall            = ec;
    mret             = mr;
    settle();
    expect_trap();
    next_cycle();
    m_mepc   = p;
    m_mcause = cause;
    m_mtval  = tval;
    read_csr(addr_mcause, m_mcause);
    read_csr(addr_mtval, m_mtval);
    read_csr(addr_mepc, {m_mepc[31:2], 2'b00});
    read_csr(addr_mscratch, m_mscratch);
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    lfsr       = 32'h6900;
    m_mtvec    = 32'h100;
    m_mscratch = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_mtval    = '0;
    idle_inputs();
    // keep tb activity off the clock edges
    #0.5;
    repeat (5) wait_fall();
    rst = 1'b0;
    settle();
    check_bit("rd_we", rd_we, 1'b0);
    check_bit("trap", trap, 1'b0);
    check_bit("redirect", redirect, 1'b0);

    // reset values of the identification CSRs and mtvec
    read_csr(addr_misa, 32'h4000_0100);
    read_csr(addr_mvendorid, 32'h0);
    read_csr(addr_marchid, 32'h0);
    read_csr(addr_mhartid, 32'd3);
    read_csr(addr_mtvec, 32'h100);

    // write, set, clear and pure read on mscratch
    for (int i = 0; i < 3; i++) begin
      w = rand_word();
      do_op(csr_write, addr_mscratch, w, 1'b0, m_mscratch);
      m_mscratch = w;
      read_csr(addr_mscratch, m_mscratch);
      s = rand_word();
      do_op(csr_set, addr_mscratch, s, 1'b0, m_mscratch);
      m_mscratch = m_mscratch | s;
      read_csr(addr_mscratch, m_mscratch);
      s = rand_word();
      do_op(csr_clear, addr_mscratch, s, 1'b0, m_mscratch);
      m_mscratch = m_mscratch & ~s;
      read_csr(addr_mscratch, m_mscratch);
    end

    // write to read-only mhartid traps as illegal
    read_csr(addr_mhartid, 32'd3);
    start_op(csr_write, addr_mhartid, rand_word(), 1'b0);
    p = pc;
    settle();
    expect_trap();
    next_cycle();
    m_mepc   = p;
    m_mcause = 32'd2;
    m_mtval  = 32'd0;
    read_csr(addr_mepc, {m_mepc[31:2], 2'b00});
    read_csr(addr_mcause, m_mcause);
    read_csr(addr_mtval, m_mtval);
    read_csr(addr_mhartid, 32'd3);

    // ranking: misaligned beats ecall, then breakpoint, then ecall alone
    p = rand_word();
    f = rand_word();
    raise(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 32'd0, f);
    p = rand_word();
    f = rand_word();
    raise(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 32'd3, p);
    p = rand_word();
    f = rand_word();
    raise(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 32'd11, 32'd0);

    // mret to the aligned mepc
    w = rand_word() | 32'h3;
    do_op(csr_write, addr_mepc, w, 1'b0, {m_mepc[31:2], 2'b00});
    m_mepc = w;
    read_csr(addr_mepc, {w[31:2], 2'b00});
    valid = 1'b1;
    mret  = 1'b1;
    pc    = rand_word();
    settle();
    check_bit("rd_we", rd_we, 1'b0);
    check_bit("trap", trap, 1'b0);
    check_bit("redirect", redirect, 1'b1);
    check_word("redirect_pc", redirect_pc, {w[31:2], 2'b00});
    next_cycle();
    // a faulting mret goes to mtvec
    p = rand_word();
    f = rand_word();
    raise(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 32'd2, 32'd0);

    // mtvec keeps direct mode and the next trap uses it
    w = rand_word();
    do_op(csr_write, addr_mtvec, w, 1'b0, m_mtvec);
    m_mtvec = {w[31:2], 2'b00};
    read_csr(addr_mtvec, m_mtvec);
    p = rand_word();
    f = rand_word();
    raise(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 32'd11, 32'd0);

    $display("PASS: all tests");
    $finish;
  end

endmodule

/* rtl/csr_unit.sv */
// ==========================================================================
// machine-mode CSR unit
// ==========================================================================
`timescale 1ns/1ps

module csr_unit #(
  parameter logic [csr_pkg::xlen-1:0] hart_id     = '0,
  parameter logic [csr_pkg::xlen-1:0] mtvec_reset = '0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     valid,
  input  csr_pkg::csr_op_e         op,
  input  csr_pkg::csr_addr_t       addr,
  input  logic [csr_pkg::xlen-1:0] src,
  input  logic                     src_zero,
  input  logic                     fetch_misaligned,
  input  logic                     illegal_instr,
  input  logic                     ebreak,
  input  logic                     ecall,
  input  logic                     mret,
  input  logic [csr_pkg::xlen-1:0] pc,
  input  logic [csr_pkg::xlen-1:0] fetch_target,
  output logic [csr_pkg::xlen-1:0] rd_data,
  output logic                     rd_we,
  output logic                     trap,
  output logic                     redirect,
  output logic [csr_pkg::xlen-1:0] redirect_pc
);
  import csr_pkg::*;

  // register file read side
  logic [xlen-1:0] rdata;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic            ro;
  // operation result
  logic            op_wr;
  logic [xlen-1:0] op_wdata;
  logic            op_illegal;
  // exception result
  logic            exc;
  logic [xlen-1:0] exc_cause;
  logic [xlen-1:0] exc_tval;
  logic            xret;
  // register file write side
  logic            wr_valid;
  logic            wr_trap;
  logic [xlen-1:0] wr_data;
  logic [xlen-1:0] wr_pc;
  logic [xlen-1:0] wr_cause;
  logic [xlen-1:0] wr_tval;

  // old CSR value goes straight back to rd
  assign rd_data = rdata;

  csr_file #(
    .hart_id     (hart_id),
    .mtvec_reset (mtvec_reset)
  ) u_csr_file (
    .clk      (clk),
    .rst      (rst),
    .addr     (addr),
    .wr_valid (wr_valid),
    .wr_trap  (wr_trap),
    .wr_data  (wr_data),
    .wr_pc    (wr_pc),
    .wr_cause (wr_cause),
    .wr_tval  (wr_tval),
    .rdata    (rdata),
    .mtvec    (mtvec),
    .mepc     (mepc),
    .ro       (ro)
  );

  csr_alu u_csr_alu (
    .op         (op),
    .src        (src),
    .rdata      (rdata),
    .src_zero   (src_zero),
    .ro         (ro),
    .op_wr      (op_wr),
    .op_wdata   (op_wdata),
    .op_illegal (op_illegal)
  );

  trap_unit u_trap_unit (
    .valid            (valid),
    .fetch_misaligned (fetch_misaligned),
    .illegal_instr    (illegal_instr),
    .ebreak           (ebreak),
    .ecall            (ecall),
    .mret             (mret),
    .pc               (pc),
    .fetch_target     (fetch_target),
    .exc              (exc),
    .exc_cause        (exc_cause),
    .exc_tval         (exc_tval),
    .xret             (xret)
  );

  commit_ctrl u_commit_ctrl (
    .valid       (valid),
    .op          (op),
    .op_wr       (op_wr),
    .op_illegal  (op_illegal),
    .exc         (exc),
    .xret        (xret),
    .op_wdata    (op_wdata),
    .exc_cause   (exc_cause),
    .exc_tval    (exc_tval),
    .pc          (pc),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .wr_valid    (wr_valid),
    .wr_trap     (wr_trap),
    .wr_data     (wr_data),
    .wr_pc       (wr_pc),
    .wr_cause    (wr_cause),
    .wr_tval     (wr_tval),
    .rd_we       (rd_we),
    .trap        (trap),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

endmodule

/* rtl/commit_ctrl.sv */
// ==========================================================================
// commit controller
// ==========================================================================
`timescale 1ns/1ps

module commit_ctrl (
  input  logic                     valid,
  input  csr_pkg::csr_op_e         op,
  input  logic                     op_wr,
  input  logic                     op_illegal,
  input  logic                     exc,
  input  logic                     xret,
  input  logic [csr_pkg::xlen-1:0] op_wdata,
  input  logic [csr_pkg::xlen-1:0] exc_cause,
  input  logic [csr_pkg::xlen-1:0] exc_tval,
  input  logic [csr_pkg::xlen-1:0] pc,
  input  logic [csr_pkg::xlen-1:0] mtvec,
  input  logic [csr_pkg::xlen-1:0] mepc,
  output logic                     wr_valid,
  output logic                     wr_trap,
  output logic [csr_pkg::xlen-1:0] wr_data,
  output logic [csr_pkg::xlen-1:0] wr_pc,
  output logic [csr_pkg::xlen-1:0] wr_cause,
  output logic [csr_pkg::xlen-1:0] wr_tval,
  output logic                     rd_we,
  output logic                     trap,
  output logic                     redirect,
  output logic [csr_pkg::xlen-1:0] redirect_pc
);
  import csr_pkg::*;

  logic take_trap;
  logic take_ret;

  // pipeline exceptions and illegal CSR writes both end in a trap
  assign take_trap = valid & (exc | op_illegal);
  // a trapping mret goes to mtvec instead
  assign take_ret  = xret & ~take_trap;

  // exception from the pipeline outranks the CSR fault
  assign wr_cause = exc ? exc_cause : cause_illegal;
  assign wr_tval  = exc ? exc_tval : '0;
  assign wr_pc    = pc;
  assign wr_data  = op_wdata;

  // trap entry replaces any CSR write of the same instruction
  assign wr_trap  = take_trap;
  assign wr_valid = take_trap | (valid & op_wr);

  // every CSR op returns the old value unless it traps
  assign rd_we = valid & ~take_trap & (op != csr_none);

  assign trap        = take_trap;
  assign redirect    = take_trap | take_ret;
  // mepc arrives already word-aligned
  assign redirect_pc = take_trap ? mtvec : mepc;

endmodule

/* rtl/trap_unit.sv */
// ==========================================================================
// exception ranking
// ==========================================================================
`timescale 1ns/1ps

module trap_unit (
  input  logic                     valid,
  input  logic                     fetch_misaligned,
  input  logic                     illegal_instr,
  input  logic                     ebreak,
  input  logic                     ecall,
  input  logic                     mret,
  input  logic [csr_pkg::xlen-1:0] pc,
  input  logic [csr_pkg::xlen-1:0] fetch_target,
  output logic                     exc,
  output logic [csr_pkg::xlen-1:0] exc_cause,
  output logic [csr_pkg::xlen-1:0] exc_tval,
  output logic                     xret
);
  import csr_pkg::*;

  always_comb begin
    exc       = 1'b0;
    exc_cause = cause_illegal;
    exc_tval  = '0;
    // highest priority first
    if (fetch_misaligned) begin
      exc       = 1'b1;
      exc_cause = cause_fetch_misaligned;
      // the faulting branch target
      exc_tval  = fetch_target;
    end else if (illegal_instr) begin
      exc       = 1'b1;
      exc_cause = cause_illegal;
    end else if (ebreak) begin
      exc       = 1'b1;
      exc_cause = cause_breakpoint;
      exc_tval  = pc;
    end else if (ecall) begin
      exc       = 1'b1;
      exc_cause = cause_ecall_m;
    end
    // nothing counts without the retire strobe
    exc = exc & valid;
  end

  // mret only returns when it did not fault itself
  assign xret = valid & mret & ~exc;

endmodule

/* rtl/csr_alu.sv */
// ==========================================================================
// CSR operation logic
// ==========================================================================
`timescale 1ns/1ps

module csr_alu (
  input  csr_pkg::csr_op_e         op,
  input  logic [csr_pkg::xlen-1:0] src,
  input  logic [csr_pkg::xlen-1:0] rdata,
  input  logic                     src_zero,
  input  logic                     ro,
  output logic                     op_wr,
  output logic [csr_pkg::xlen-1:0] op_wdata,
  output logic                     op_illegal
);
  import csr_pkg::*;

  // write intent before read-only check
  logic wr_req;

  always_comb begin
    op_wdata = rdata;
    wr_req   = 1'b0;
    case (op)
      // csrrw always writes, even from x0
      csr_write: begin
        op_wdata = src;
        wr_req   = 1'b1;
      end
      // rs1 = x0 or uimm = 0 makes set a plain read
      csr_set: begin
        op_wdata = rdata | src;
        wr_req   = !src_zero;
      end
      // same rule for clear
      csr_clear: begin
        op_wdata = rdata & ~src;
        wr_req   = !src_zero;
      end
      default: begin
        op_wdata = rdata;
        wr_req   = 1'b0;
      end
    endcase
  end

  // a real write to a read-only CSR is an illegal instruction
  assign op_illegal = wr_req & ro;
  assign op_wr      = wr_req & ~ro;

endmodule

/* rtl/csr_file.sv */
// ==========================================================================
// machine CSR register file
// ==========================================================================
`timescale 1ns/1ps

module csr_file #(
  parameter logic [csr_pkg::xlen-1:0] hart_id     = '0,
  parameter logic [csr_pkg::xlen-1:0] mtvec_reset = '0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  csr_pkg::csr_addr_t       addr,
  input  logic                     wr_valid,
  input  logic                     wr_trap,
  input  logic [csr_pkg::xlen-1:0] wr_data,
  input  logic [csr_pkg::xlen-1:0] wr_pc,
  input  logic [csr_pkg::xlen-1:0] wr_cause,
  input  logic [csr_pkg::xlen-1:0] wr_tval,
  output logic [csr_pkg::xlen-1:0] rdata,
  output logic [csr_pkg::xlen-1:0] mtvec,
  output logic [csr_pkg::xlen-1:0] mepc,
  output logic                     ro
);
  import csr_pkg::*;

  // registered state and next state
  logic [xlen-1:0] mvendorid_q, mvendorid_d;
  logic [xlen-1:0] marchid_q, marchid_d;
  logic [xlen-1:0] mhartid_q, mhartid_d;
  logic [xlen-1:0] misa_q, misa_d;
  logic [xlen-1:0] mtvec_q, mtvec_d;
  logic [xlen-1:0] mscratch_q, mscratch_d;
  logic [xlen-1:0] mepc_q, mepc_d;
  logic [xlen-1:0] mcause_q, mcause_d;
  logic [xlen-1:0] mtval_q, mtval_d;

  // fixed by the standard encoding, top two bits 11 mean read-only
  assign ro = (addr[11:10] == 2'b11);

  // fetch only ever sees an aligned target
  assign mtvec = mtvec_q;
  assign mepc  = {mepc_q[xlen-1:2], 2'b00};

  // read port, unimplemented addresses read zero
  always_comb begin
    rdata = '0;
    case (addr)
      addr_mvendorid: rdata = mvendorid_q;
      addr_marchid:   rdata = marchid_q;
      addr_mhartid:   rdata = mhartid_q;
      addr_misa:      rdata = misa_q;
      addr_mtvec:     rdata = mtvec_q;
      addr_mscratch:  rdata = mscratch_q;
      // IALIGN is 32, low bits never visible
      addr_mepc:      rdata = {mepc_q[xlen-1:2], 2'b00};
      addr_mcause:    rdata = mcause_q;
      addr_mtval:     rdata = mtval_q;
      default:        rdata = '0;
    endcase
  end

  // write port, trap entry or one CSR write
  always_comb begin
    mvendorid_d = mvendorid_q;
    marchid_d   = marchid_q;
    mhartid_d   = mhartid_q;
    misa_d      = misa_q;
    mtvec_d     = mtvec_q;
    mscratch_d  = mscratch_q;
    mepc_d      = mepc_q;
    mcause_d    = mcause_q;
    mtval_d     = mtval_q;
    if (wr_valid) begin
      if (wr_trap) begin
        // trap entry saves pc, cause and value together
        mepc_d   = wr_pc;
        mcause_d = wr_cause;
        mtval_d  = wr_tval;
      end else begin
        // read-only and unknown addresses fall to default
        case (addr)
          // direct mode only, mode field stays zero
          addr_mtvec:    mtvec_d = {wr_data[xlen-1:2], 2'b00};
          addr_mscratch: mscratch_d = wr_data;
          addr_mepc:     mepc_d = wr_data;
          addr_mcause:   mcause_d = wr_data;
          addr_mtval:    mtval_d = wr_data;
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      // non-commercial, no arch id assigned
      mvendorid_q <= '0;
      marchid_q   <= '0;
      mhartid_q   <= hart_id;
      misa_q      <= misa_rv32i;
      mtvec_q     <= {mtvec_reset[xlen-1:2], 2'b00};
      mscratch_q  <= '0;
      mepc_q      <= '0;
      mcause_q    <= '0;
      mtval_q     <= '0;
    end else begin
      mvendorid_q <= mvendorid_d;
      marchid_q   <= marchid_d;
      mhartid_q   <= mhartid_d;
      misa_q      <= misa_d;
      mtvec_q     <= mtvec_d;
      mscratch_q  <= mscratch_d;
      mepc_q      <= mepc_d;
      mcause_q    <= mcause_d;
      mtval_q     <= mtval_d;
    end
  end

endmodule

/* rtl/csr_pkg.sv */
// ==========================================================================
// machine-mode CSR definitions
// ==========================================================================

package csr_pkg;

  // RV32 only
  localparam int xlen = 32;

  // CSR operation carried by the retiring instruction
  typedef enum logic [1:0] {
    csr_none  = 2'd0,
    csr_write = 2'd1,
    csr_set   = 2'd2,
    csr_clear = 2'd3
  } csr_op_e;

  typedef logic [11:0] csr_addr_t;

  // machine information registers, read-only
  localparam csr_addr_t addr_mvendorid = 12'hf11;
  localparam csr_addr_t addr_marchid   = 12'hf12;
  localparam csr_addr_t addr_mhartid   = 12'hf14;

  // machine trap setup and handling
  localparam csr_addr_t addr_misa      = 12'h301;
  localparam csr_addr_t addr_mtvec     = 12'h305;
  localparam csr_addr_t addr_mscratch  = 12'h340;
  localparam csr_addr_t addr_mepc      = 12'h341;
  localparam csr_addr_t addr_mcause    = 12'h342;
  localparam csr_addr_t addr_mtval     = 12'h343;

  // synchronous exception codes written to mcause
  localparam logic [xlen-1:0] cause_fetch_misaligned = xlen'(0);
  localparam logic [xlen-1:0] cause_illegal          = xlen'(2);
  localparam logic [xlen-1:0] cause_breakpoint       = xlen'(3);
  localparam logic [xlen-1:0] cause_ecall_m          = xlen'(11);

  // mxl = 1 (32 bit), extension bit 8 = I
  localparam logic [xlen-1:0] misa_rv32i = 32'h4000_0100;

endpackage
